//--- common/host_chan_pkg.sv
// Sizes are fixed for a 64-line ring of 512-bit lines and the register map assumes word-wide CSR access
`default_nettype none

package host_chan_pkg;

    // ======================================================================
    // Ring geometry
    // ======================================================================

    // Width of a ring index, which gives a ring of 64 lines
    localparam int IDX_BITS = 6;
    typedef logic [IDX_BITS-1:0] t_ring_idx;

    // One message line as it is written to host memory
    localparam int LINE_BITS = 512;
    typedef logic [LINE_BITS-1:0] t_line;

    // Host memory is addressed in whole lines
    localparam int ADDR_BITS = 42;
    typedef logic [ADDR_BITS-1:0] t_line_addr;

    // ======================================================================
    // Flow control and flush policy
    // ======================================================================

    // Requests the memory side accepts before any credit comes back
    localparam int MEM_CREDITS = 4;

    // Issue-capable idle cycles that force a fence on a partial run
    localparam int IDLE_FLUSH_CYCLES = 16;

    // ======================================================================
    // Register map
    // ======================================================================

    localparam int CSR_ADDR_BITS = 2;

    // Base line address of the ring in host memory
    localparam logic [CSR_ADDR_BITS-1:0] CSR_RING_BASE = 2'd0;
    // Bit 0 lets the writer issue requests
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ENABLE = 2'd1;
    // Oldest ring entry the host has not consumed yet
    localparam logic [CSR_ADDR_BITS-1:0] CSR_OLDEST_IDX = 2'd2;
    // Read-only view of the published write index
    localparam logic [CSR_ADDR_BITS-1:0] CSR_NEXT_IDX = 2'd3;

endpackage

`default_nettype wire

//--- common/mem_write_if.sv
// Requests are held by the writer until grant and each grant stands for exactly one line or fence
`timescale 1ns/1ps
`default_nettype none

interface mem_write_if;
    import host_chan_pkg::*;

    // Writer wants a slot toward memory this cycle
    logic request;
    // The pending request is a write fence rather than a line
    logic fence;
    // Target line address, zero for a fence
    t_line_addr addr;
    // Line payload, ignored by memory for a fence
    t_line data;

    // The controller took the request this cycle
    logic grant;
    // At least one credit is left
    logic can_issue;

    // Ring writer side
    modport writer
    (
        output request, fence, addr, data,
        input  grant, can_issue
    );

    // Credit controller side
    modport ctrl
    (
        input  request, fence, addr, data,
        output grant, can_issue
    );

endinterface

`default_nettype wire

//--- fifo_to_host/line_buffer.sv
// Holds two lines only and expects the caller to respect not_full and not_empty
`timescale 1ns/1ps
`default_nettype none

module line_buffer
(
    input  logic                 clk,
    input  logic                 reset,
    input  host_chan_pkg::t_line enq_data,
    input  logic                 enq_en,
    output logic                 not_full,
    output host_chan_pkg::t_line first,
    input  logic                 deq_en,
    output logic                 not_empty
);
    import host_chan_pkg::*;

    // Two storage slots addressed by one-bit pointers
    t_line      entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    // Payload storage only changes on an enqueue
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            entry[wr_ptr] <= enq_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (deq_en)
            begin
                rd_ptr <= ~rd_ptr;
            end
            // Simultaneous enqueue and dequeue leave the count unchanged
            if (enq_en && !deq_en)
            begin
                count <= count + 2'd1;
            end
            else if (deq_en && !enq_en)
            begin
                count <= count - 2'd1;
            end
        end
    end

    // Head of the queue is visible the cycle after it was written
    assign first     = entry[rd_ptr];
    assign not_full  = (count != 2'd2);
    assign not_empty = (count != 2'd0);

    // The writer may only take a line that is already stored
    a_no_deq_empty: assert property (@(posedge clk) disable iff (reset) deq_en |-> not_empty)
        else $error("line_buffer: dequeue from empty buffer");

    // The producer side must honor tx_rdy
    a_no_enq_full: assert property (@(posedge clk) disable iff (reset) enq_en |-> not_full)
        else $error("line_buffer: enqueue into full buffer");

endmodule

`default_nettype wire

//--- fifo_to_host/fifo_to_host_writer.sv
// Single writer only and the host must never report an oldest index beyond the published one
`timescale 1ns/1ps
`default_nettype none

module fifo_to_host_writer
(
    input  logic                       clk,
    input  logic                       reset,
    input  host_chan_pkg::t_line       line_data,
    input  logic                       line_valid,
    output logic                       line_deq,
    input  host_chan_pkg::t_line_addr  ring_base,
    input  logic                       enable,
    input  host_chan_pkg::t_ring_idx   oldest_idx,
    output host_chan_pkg::t_ring_idx   next_idx,
    mem_write_if.writer                mem
);
    import host_chan_pkg::*;

    // ======================================================================
    // Ring indices
    // ======================================================================

    // Next ring entry a line will be written to
    t_ring_idx cur_idx;

    // Entries before this one are fenced and visible to the host
    t_ring_idx written_idx;

    // Lines written since the last fence
    t_ring_idx ring_dist;

    assign next_idx  = written_idx;
    assign ring_dist = cur_idx - written_idx;

    // A nonzero top pair of bits means the run covers a quarter of the ring
    logic flush_for_writes;
    assign flush_for_writes = (ring_dist[IDX_BITS-1:IDX_BITS-2] != 2'b00);

    // Full check is registered, so it looks two entries ahead to cover the lag
    logic ring_ok;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ring_ok <= 1'b0;
        end
        else
        begin
            ring_ok <= (cur_idx + t_ring_idx'(1) != oldest_idx) &&
                       (cur_idx + t_ring_idx'(2) != oldest_idx);
        end
    end

    // ======================================================================
    // Flush decision
    // ======================================================================

    typedef enum logic [1:0]
    {
        ST_WAIT_FIRST,
        ST_COLLECT,
        ST_FENCE
    } t_state;

    t_state state;

    typedef logic [$clog2(IDLE_FLUSH_CYCLES):0] t_idle_cnt;

    t_idle_cnt idle_cnt;
    logic      flush_for_idle;
    logic      flush_now;

    assign flush_for_idle = (idle_cnt == t_idle_cnt'(IDLE_FLUSH_CYCLES));

    // Only an open run can be closed by a fence
    assign flush_now = (state == ST_COLLECT) && (flush_for_idle || flush_for_writes);

    // Idle cycles only count while memory could have taken a request,
    // so a saturated bus does not trigger needless fences
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            idle_cnt <= '0;
        end
        else if ((state != ST_COLLECT) || line_deq)
        begin
            idle_cnt <= '0;
        end
        else if (mem.can_issue && !flush_for_idle)
        begin
            idle_cnt <= idle_cnt + t_idle_cnt'(1);
        end
    end

    // ======================================================================
    // Fence state machine
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= ST_WAIT_FIRST;
            cur_idx     <= '0;
            written_idx <= '0;
        end
        else
        begin
            case (state)
                ST_WAIT_FIRST:
                begin
                    // First line of a new run
                    if (mem.grant)
                    begin
                        state   <= ST_COLLECT;
                        cur_idx <= cur_idx + t_ring_idx'(1);
                    end
                end

                ST_COLLECT:
                begin
                    // Line requests are held off while a flush is due
                    if (flush_now)
                    begin
                        state <= ST_FENCE;
                    end
                    else if (mem.grant)
                    begin
                        cur_idx <= cur_idx + t_ring_idx'(1);
                    end
                end

                ST_FENCE:
                begin
                    // Publish the run once the fence is accepted
                    if (mem.grant)
                    begin
                        state       <= ST_WAIT_FIRST;
                        written_idx <= cur_idx;
                    end
                end

                default:
                begin
                    state <= ST_WAIT_FIRST;
                end
            endcase
        end
    end

    // ======================================================================
    // Request generation
    // ======================================================================

    logic line_req;
    logic fence_req;

    // A line needs ring space; a fence never does, or the host could not drain
    assign line_req  = enable && ring_ok && line_valid && (state != ST_FENCE) && !flush_now;
    assign fence_req = enable && (state == ST_FENCE);

    assign mem.request = line_req || fence_req;
    assign mem.fence   = (state == ST_FENCE);
    assign mem.addr    = (state == ST_FENCE) ? '0 : ring_base + t_line_addr'(cur_idx);
    assign mem.data    = line_data;

    // A granted line leaves the buffer in the grant cycle
    assign line_deq = mem.grant && (state != ST_FENCE);

endmodule

`default_nettype wire

//--- source/host_chan_csr.sv
// Registers are write-only except for readback and CSR_NEXT_IDX ignores writes
`timescale 1ns/1ps
`default_nettype none

module host_chan_csr
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    wr_en,
    input  logic [host_chan_pkg::CSR_ADDR_BITS-1:0] addr,
    input  logic [63:0]                             wr_data,
    output logic [63:0]                             rd_data,
    input  host_chan_pkg::t_ring_idx                next_idx,
    output host_chan_pkg::t_line_addr               ring_base,
    output logic                                    enable,
    output host_chan_pkg::t_ring_idx                oldest_idx
);
    import host_chan_pkg::*;

    // ======================================================================
    // Register storage
    // ======================================================================

    t_line_addr base_q;
    logic       enable_q;
    t_ring_idx  oldest_q;

    // Writes land on the next edge and the writer sees them one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            base_q   <= '0;
            enable_q <= 1'b0;
            oldest_q <= '0;
        end
        else if (wr_en)
        begin
            case (addr)
                CSR_RING_BASE:
                begin
                    base_q <= t_line_addr'(wr_data);
                end

                CSR_ENABLE:
                begin
                    enable_q <= wr_data[0];
                end

                CSR_OLDEST_IDX:
                begin
                    // Host reports how far it has consumed the ring
                    oldest_q <= t_ring_idx'(wr_data);
                end

                default:
                begin
                    // The published index is owned by the writer
                end
            endcase
        end
    end

    assign ring_base  = base_q;
    assign enable     = enable_q;
    assign oldest_idx = oldest_q;

    // ======================================================================
    // Readback
    // ======================================================================

    // Reads are combinational and zero-extended to the bus width
    always_comb
    begin
        case (addr)
            CSR_RING_BASE:
            begin
                rd_data = 64'(base_q);
            end

            CSR_ENABLE:
            begin
                rd_data = 64'(enable_q);
            end

            CSR_OLDEST_IDX:
            begin
                rd_data = 64'(oldest_q);
            end

            default:
            begin
                rd_data = 64'(next_idx);
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/write_credit_ctrl.sv
// Memory must return exactly one credit per granted request and never more than MEM_CREDITS
`timescale 1ns/1ps
`default_nettype none

module write_credit_ctrl
(
    input  logic                       clk,
    input  logic                       reset,
    mem_write_if.ctrl                  ch,
    input  logic                       credit_return,
    output logic                       wr_valid,
    output logic                       wr_fence,
    output host_chan_pkg::t_line_addr  wr_addr,
    output host_chan_pkg::t_line       wr_data
);
    import host_chan_pkg::*;

    typedef logic [$clog2(MEM_CREDITS+1)-1:0] t_credit_cnt;

    // Credits still available toward memory
    t_credit_cnt credits;

    assign ch.can_issue = (credits != '0);

    // Grant in the request cycle whenever a credit is left
    assign ch.grant = ch.request && ch.can_issue;

    // A grant and a return in the same cycle cancel out
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits <= t_credit_cnt'(MEM_CREDITS);
        end
        else if (ch.grant && !credit_return)
        begin
            credits <= credits - t_credit_cnt'(1);
        end
        else if (credit_return && !ch.grant)
        begin
            credits <= credits + t_credit_cnt'(1);
        end
    end

    // Each granted request shows up on the memory ports as one valid cycle
    assign wr_valid = ch.grant;
    assign wr_fence = ch.grant && ch.fence;
    assign wr_addr  = ch.addr;
    assign wr_data  = ch.data;

    // An extra credit from memory overflows the count, and an underflow
    // wraps to a large value, so both show up above MEM_CREDITS
    a_credit_range: assert property (@(posedge clk) disable iff (reset)
        credits <= t_credit_cnt'(MEM_CREDITS))
        else $error("write_credit_ctrl: credit count out of range");

endmodule

`default_nettype wire

//--- source/host_chan_top.sv
// Producer lines are accepted only while tx_rdy is high and nothing issues until enable is set
`timescale 1ns/1ps
`default_nettype none

module host_chan_top
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  host_chan_pkg::t_line                    tx_data,
    input  logic                                    tx_enable,
    output logic                                    tx_rdy,
    input  logic                                    csr_wr_en,
    input  logic [host_chan_pkg::CSR_ADDR_BITS-1:0] csr_addr,
    input  logic [63:0]                             csr_wr_data,
    output logic [63:0]                             csr_rd_data,
    output logic                                    mem_wr_valid,
    output logic                                    mem_wr_fence,
    output host_chan_pkg::t_line_addr               mem_wr_addr,
    output host_chan_pkg::t_line                    mem_wr_data,
    input  logic                                    mem_credit_return,
    output host_chan_pkg::t_ring_idx                next_write_idx
);
    import host_chan_pkg::*;

    // Buffered line toward the writer
    t_line buf_first;
    logic  buf_not_empty;
    logic  buf_deq;

    // Register outputs steering the writer
    t_line_addr ring_base;
    logic       enable;
    t_ring_idx  oldest_idx;

    // Writer to credit controller request channel
    mem_write_if mem_ch ();

    // Incoming lines are accepted only on a ready cycle
    line_buffer line_buffer_i (.clk, .reset, .enq_data(tx_data),
        .enq_en(tx_enable && tx_rdy), .not_full(tx_rdy), .first(buf_first),
        .deq_en(buf_deq), .not_empty(buf_not_empty));

    fifo_to_host_writer fifo_to_host_writer_i (.clk, .reset, .line_data(buf_first),
        .line_valid(buf_not_empty), .line_deq(buf_deq), .ring_base, .enable,
        .oldest_idx, .next_idx(next_write_idx), .mem(mem_ch.writer));

    host_chan_csr host_chan_csr_i (.clk, .reset, .wr_en(csr_wr_en), .addr(csr_addr),
        .wr_data(csr_wr_data), .rd_data(csr_rd_data), .next_idx(next_write_idx),
        .ring_base, .enable, .oldest_idx);

    write_credit_ctrl write_credit_ctrl_i (.clk, .reset, .ch(mem_ch.ctrl),
        .credit_return(mem_credit_return), .wr_valid(mem_wr_valid),
        .wr_fence(mem_wr_fence), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data));

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Free-running clock with a fixed 40 ns period that starts low at time zero
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic clk
);
    localparam realtime HALF_PERIOD = 20ns;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- test/host_chan_checker.sv
// Samples every DUT port on the rising edge and assumes CSR writes only come from the testbench
`timescale 1ns/1ps
`default_nettype none

module host_chan_checker
(
    input logic                                    clk,
    input logic                                    reset,
    input host_chan_pkg::t_line                    tx_data,
    input logic                                    tx_enable,
    input logic                                    tx_rdy,
    input logic                                    csr_wr_en,
    input logic [host_chan_pkg::CSR_ADDR_BITS-1:0] csr_addr,
    input logic [63:0]                             csr_wr_data,
    input logic [63:0]                             csr_rd_data,
    input logic                                    mem_wr_valid,
    input logic                                    mem_wr_fence,
    input host_chan_pkg::t_line_addr               mem_wr_addr,
    input host_chan_pkg::t_line                    mem_wr_data,
    input logic                                    mem_credit_return,
    input host_chan_pkg::t_ring_idx                next_write_idx
);
    import host_chan_pkg::*;

    // A run may cover at most a quarter of the ring
    localparam int QUARTER = (1 << IDX_BITS) / 4;
    // Idle flush plus the worst credit wait and some slack
    localparam int FENCE_BOUND = IDLE_FLUSH_CYCLES + MEM_CREDITS * 5 + 16;

    // ======================================================================
    // Reference model state
    // ======================================================================

    string      cur_test = "reset";
    int         err_count = 0;
    t_line      exp_q [$];
    int         lines_written;
    int         run_len;
    int         since_line;
    int         outstanding;
    logic       fence_pending;
    t_ring_idx  fence_exp;
    t_line_addr base_model;
    logic       en_model;
    t_ring_idx  oldest_model;

    task automatic report_value(input string what, input logic [511:0] exp_v,
                                input logic [511:0] act_v);
        $display("error %s %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
        err_count++;
    endtask

    task automatic report_fail(input string msg);
        $display("failure in %s: %s", cur_test, msg);
        err_count++;
    endtask

    always @(posedge clk)
    begin
        t_line     exp_line;
        t_ring_idx exp_idx;
        if (reset)
        begin
            exp_q.delete();
            lines_written = 0;
            run_len       = 0;
            since_line    = 0;
            outstanding   = 0;
            fence_pending = 1'b0;
            base_model    = '0;
            en_model      = 1'b0;
            oldest_model  = '0;
        end
        else
        begin
            // The published index moves on the edge after a fence grant
            if (fence_pending)
            begin
                if (next_write_idx != fence_exp)
                    report_value("next_write_idx", fence_exp, next_write_idx);
                if (!csr_wr_en && csr_addr == CSR_NEXT_IDX && csr_rd_data != 64'(fence_exp))
                    report_value("csr next_idx", fence_exp, csr_rd_data);
                fence_pending = 1'b0;
            end

            if (mem_wr_valid)
            begin
                if (!en_model)
                    report_fail("a write issued while the channel was disabled");
                if (mem_wr_fence)
                begin
                    if (mem_wr_addr != '0)
                        report_value("fence addr", 0, mem_wr_addr);
                    fence_pending = 1'b1;
                    fence_exp     = t_ring_idx'(lines_written);
                    run_len       = 0;
                end
                else
                begin
                    exp_idx = t_ring_idx'(lines_written);
                    if (exp_q.size() == 0)
                    begin
                        report_fail("a line write appeared with no accepted line left");
                    end
                    else
                    begin
                        exp_line = exp_q.pop_front();
                        if (mem_wr_data != exp_line)
                            report_value("line data", exp_line, mem_wr_data);
                    end
                    if (mem_wr_addr != base_model + t_line_addr'(exp_idx))
                        report_value("line addr", base_model + t_line_addr'(exp_idx),
                                     mem_wr_addr);
                    // Ring counts as full one entry early, so 62 ahead is the limit
                    if (t_ring_idx'(exp_idx - oldest_model) > t_ring_idx'(62))
                        report_fail("a line overran entries the host had not consumed");
                    lines_written++;
                    run_len++;
                    since_line = 0;
                    if (run_len > QUARTER)
                        report_fail("a run of line writes went past a quarter of the ring");
                end
            end
            else if (run_len > 0)
            begin
                since_line++;
                if (since_line > FENCE_BOUND)
                begin
                    report_fail("no fence followed an open run in time");
                    since_line = 0;
                end
            end

            // Granted requests not yet answered by a credit
            outstanding = outstanding + (mem_wr_valid ? 1 : 0) - (mem_credit_return ? 1 : 0);
            if (outstanding > MEM_CREDITS || outstanding < 0)
                report_value("outstanding", MEM_CREDITS, outstanding);

            // A line issues no earlier than the cycle after acceptance
            if (tx_enable && tx_rdy)
                exp_q.push_back(tx_data);

            // Register model follows the same edge as the DUT
            if (csr_wr_en)
            begin
                case (csr_addr)
                    CSR_RING_BASE:  base_model   = t_line_addr'(csr_wr_data);
                    CSR_ENABLE:     en_model     = csr_wr_data[0];
                    CSR_OLDEST_IDX: oldest_model = t_ring_idx'(csr_wr_data);
                    default:        ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- test/host_chan_tb.sv
// Drives a fixed-seed random run of 382 lines and relies on the checker for all data comparisons
`timescale 1ns/1ps
`default_nettype none

module host_chan_tb;
    import host_chan_pkg::*;

    localparam int         TOTAL_LINES     = 382;
    localparam int         PER_LINE_CYCLES = 40;
    localparam longint     WATCHDOG_NS     = (TOTAL_LINES * PER_LINE_CYCLES + 2000) * 40;
    localparam t_line_addr BASE_A          = 42'h000_0001_0000;
    localparam t_line_addr BASE_B          = 42'h123_4567_0040;

    logic                     clk;
    logic                     reset;
    t_line                    tx_data;
    logic                     tx_enable;
    logic                     tx_rdy;
    logic                     csr_wr_en;
    logic [CSR_ADDR_BITS-1:0] csr_addr;
    logic [63:0]              csr_wr_data;
    logic [63:0]              csr_rd_data;
    logic                     mem_wr_valid;
    logic                     mem_wr_fence;
    t_line_addr               mem_wr_addr;
    t_line                    mem_wr_data;
    logic                     mem_credit_return;
    t_ring_idx                next_write_idx;

    logic host_paused = 1'b1;
    int   cycle = 0;
    int   tb_errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   errors_at_start;
    int   credit_due [$];
    int   seed_val;

    tb_clock clock_i (.clk);

    host_chan_top host_chan_top_i (.*);

    host_chan_checker checker_i (.*);

    // ======================================================================
    // Memory and host models
    // ======================================================================

    // Each grant is answered by one credit 1 to 5 cycles later
    always @(posedge clk)
    begin
        cycle++;
        if (!reset && mem_wr_valid)
            credit_due.push_back(cycle + $urandom_range(5, 1));
    end

    // Only one credit can come back per cycle, so due credits may queue up
    always @(negedge clk)
    begin
        mem_credit_return = 1'b0;
        foreach (credit_due[i])
        begin
            if (credit_due[i] <= cycle && !mem_credit_return)
            begin
                credit_due.delete(i);
                mem_credit_return = 1'b1;
                break;
            end
        end
    end

    // Host consumes up to the published index at random intervals
    initial
    begin
        forever
        begin
            repeat ($urandom_range(40, 5)) @(negedge clk);
            if (!host_paused)
            begin
                csr_wr_en   = 1'b1;
                csr_addr    = CSR_OLDEST_IDX;
                csr_wr_data = 64'(next_write_idx);
                @(negedge clk);
                csr_wr_en = 1'b0;
                csr_addr  = CSR_NEXT_IDX;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    function automatic int total_errors();
        return tb_errors + checker_i.err_count;
    endfunction

    task automatic csr_write(input logic [CSR_ADDR_BITS-1:0] a, input logic [63:0] d);
        @(negedge clk);
        csr_wr_en   = 1'b1;
        csr_addr    = a;
        csr_wr_data = d;
        @(negedge clk);
        csr_wr_en = 1'b0;
        csr_addr  = CSR_NEXT_IDX;
    endtask

    // Host writes finish within a cycle, so three cycles make the bus free
    task automatic pause_host();
        host_paused = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    task automatic drive_line(input t_line d);
        while (!tx_rdy)
            @(negedge clk);
        tx_data   = d;
        tx_enable = 1'b1;
        @(negedge clk);
        tx_enable = 1'b0;
    endtask

    task automatic push_random(input int n);
        t_line d;
        for (int i = 0; i < n; i++)
        begin
            for (int w = 0; w < LINE_BITS / 32; w++)
                d[w*32 +: 32] = $urandom;
            drive_line(d);
            if ($urandom_range(3, 0) == 0)
                repeat ($urandom_range(6, 1)) @(negedge clk);
        end
    endtask

    // Wait until every accepted line is written and its run fenced
    task automatic drain();
        int waited;
        waited = 0;
        while (checker_i.exp_q.size() != 0 || checker_i.run_len != 0 || checker_i.fence_pending)
        begin
            @(negedge clk);
            waited++;
            if (waited > 3000)
            begin
                $display("drain in %s timed out with lines still pending", checker_i.cur_test);
                tb_errors++;
                break;
            end
        end
    endtask

    task automatic begin_test(input string name);
        checker_i.cur_test = name;
        errors_at_start    = total_errors();
        tests_run++;
    endtask

    task automatic end_test();
        int n;
        n = total_errors() - errors_at_start;
        if (n != 0)
            tests_failed++;
        $display("test %s: %s (%0d errors)", checker_i.cur_test, (n == 0) ? "ok" : "bad", n);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        int stalled_at;
        seed_val          = $urandom(32'hd845);
        reset             = 1'b1;
        tx_data           = '0;
        tx_enable         = 1'b0;
        csr_wr_en         = 1'b0;
        csr_addr          = CSR_NEXT_IDX;
        csr_wr_data       = '0;
        mem_credit_return = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        csr_write(CSR_RING_BASE, 64'(BASE_A));

        // Lines wait in the buffer while the channel is disabled
        begin_test("disabled_hold");
        drive_line({16{32'h0bad_f00d}});
        drive_line({16{32'h1234_5678}});
        if (tx_rdy)
        begin
            $display("tx_rdy stayed high with two lines buffered");
            tb_errors++;
        end
        repeat (20) @(negedge clk);
        if (checker_i.lines_written != 0)
        begin
            $display("lines were written before enable was set");
            tb_errors++;
        end
        csr_write(CSR_ENABLE, 64'd1);
        host_paused = 1'b0;
        drain();
        end_test();

        begin_test("random_stream");
        push_random(150);
        drain();
        pause_host();
        csr_write(CSR_RING_BASE, 64'(BASE_B));
        host_paused = 1'b0;
        push_random(150);
        drain();
        end_test();

        // With the host paused the ring fills and writes must stall
        begin_test("ring_full");
        pause_host();
        fork
            push_random(80);
            begin
                repeat (300) @(negedge clk);
                stalled_at = checker_i.lines_written;
                repeat (100) @(negedge clk);
                if (checker_i.lines_written != stalled_at)
                begin
                    $display("writes kept going with the ring full");
                    tb_errors++;
                end
                // Full is flagged at 62 entries and the lagging check can let one more in
                if (t_ring_idx'(stalled_at - checker_i.oldest_model) < t_ring_idx'(62))
                begin
                    $display("error ring_full occupancy expected 62 or 63 actual %0d",
                             t_ring_idx'(stalled_at - checker_i.oldest_model));
                    tb_errors++;
                end
                host_paused = 1'b0;
            end
        join
        drain();
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0 && tests_failed == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
common/host_chan_pkg.sv
common/mem_write_if.sv
fifo_to_host/line_buffer.sv
fifo_to_host/fifo_to_host_writer.sv
source/host_chan_csr.sv
source/write_credit_ctrl.sv
source/host_chan_top.sv
test/tb_clock.sv
test/host_chan_checker.sv
test/host_chan_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module host_chan_tb \
    -o sim_host_chan

./obj_dir/sim_host_chan > sim.log 2>&1 || true
cat sim.log

grep -q "Result: PASSED" sim.log || exit 1
exit 0
